/* rtl/cdc_pkg.sv */
//**********************************************************
// Shared widths, FIFO depth, request union and response
// word for the isolated clock-crossing request channel
//**********************************************************

package cdc_pkg;

  // Register file geometry
  localparam int unsigned RegAddrWidth = 4;
  localparam int unsigned RegDataWidth = 32;

  // FIFO depth is 2**LogDepth entries
  localparam int unsigned LogDepth   = 3;
  localparam int unsigned SyncStages = 2;

  // Kept below the FIFO depth so the request FIFO cannot overflow
  localparam int unsigned MaxPending = 6;
  localparam int unsigned PendWidth  = $clog2(MaxPending + 1);

  // Payload word, read as data on a write and as a mask on a read
  typedef union packed {
    struct packed {
      logic [RegDataWidth-1:0] data;
    } wr;
    struct packed {
      logic [RegDataWidth-1:0] mask;
    } rd;
  } req_payload_u;

  // op is 1 for a write
  typedef struct packed {
    logic                    op;
    logic [RegAddrWidth-1:0] addr;
    req_payload_u            payload;
  } req_word_t;

  localparam int unsigned ReqWidth = $bits(req_word_t);

  // Response word on both sides of the return FIFO
  typedef logic [RegDataWidth-1:0] rsp_word_t;

endpackage

/* rtl/cdc_async_fifo.sv */
//**********************************************************
// Dual-clock FIFO with gray-coded pointers and synchronizers
//**********************************************************

`timescale 1ns/1ns

module cdc_async_fifo
  import cdc_pkg::*;
#(
  parameter int unsigned Width = 32
) (
  input  logic             wr_clk_i,
  input  logic             rd_clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [Width-1:0] wdata_i,
  input  logic             pop_i,
  output logic [Width-1:0] rdata_o,
  output logic             empty_o,
  output logic             full_o
);

  logic [Width-1:0] mem_q [2**LogDepth];

  // Pointers carry one extra wrap bit above the address
  logic [LogDepth:0] wr_bin_q;
  logic [LogDepth:0] wr_gray_q;
  logic [LogDepth:0] rd_bin_q;
  logic [LogDepth:0] rd_gray_q;
  logic [LogDepth:0] wr_bin_next;
  logic [LogDepth:0] rd_bin_next;
  logic [LogDepth:0] wr_gray_rd;
  logic [LogDepth:0] rd_gray_wr;

  // Synchronizer chains, stage 0 samples the other domain
  logic [SyncStages-1:0][LogDepth:0] wr_gray_sync_q;
  logic [SyncStages-1:0][LogDepth:0] rd_gray_sync_q;

  function automatic logic [LogDepth:0] bin2gray(input logic [LogDepth:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  assign wr_bin_next = wr_bin_q + {{LogDepth{1'b0}}, 1'b1};
  assign rd_bin_next = rd_bin_q + {{LogDepth{1'b0}}, 1'b1};

  // Write side
  always_ff @(posedge wr_clk_i) begin
    if (rst_i) begin
      wr_bin_q  <= '0;
      wr_gray_q <= '0;
    end else if (push_i) begin
      wr_bin_q  <= wr_bin_next;
      wr_gray_q <= bin2gray(wr_bin_next);
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (push_i) begin
      mem_q[wr_bin_q[LogDepth-1:0]] <= wdata_i;
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (rst_i) begin
      rd_gray_sync_q <= '0;
    end else begin
      rd_gray_sync_q <= {rd_gray_sync_q[SyncStages-2:0], rd_gray_q};
    end
  end

  assign rd_gray_wr = rd_gray_sync_q[SyncStages-1];

  // Full when the top two gray bits differ and the rest match
  assign full_o = (wr_gray_q == {~rd_gray_wr[LogDepth:LogDepth-1],
                                 rd_gray_wr[LogDepth-2:0]});

  // Read side
  always_ff @(posedge rd_clk_i) begin
    if (rst_i) begin
      rd_bin_q  <= '0;
      rd_gray_q <= '0;
    end else if (pop_i) begin
      rd_bin_q  <= rd_bin_next;
      rd_gray_q <= bin2gray(rd_bin_next);
    end
  end

  always_ff @(posedge rd_clk_i) begin
    if (rst_i) begin
      wr_gray_sync_q <= '0;
    end else begin
      wr_gray_sync_q <= {wr_gray_sync_q[SyncStages-2:0], wr_gray_q};
    end
  end

  assign wr_gray_rd = wr_gray_sync_q[SyncStages-1];
  assign empty_o    = (rd_gray_q == wr_gray_rd);
  assign rdata_o    = mem_q[rd_bin_q[LogDepth-1:0]];

  // No back-pressure, so both ends must stay within bounds
  assert property (@(posedge wr_clk_i) disable iff (rst_i) push_i |-> !full_o)
    else $error("FIFO push while full");

  assert property (@(posedge rd_clk_i) disable iff (rst_i) pop_i |-> !empty_o)
    else $error("FIFO pop while empty");

endmodule

/* rtl/cdc_req_isolate.sv */
//**********************************************************
// Isolation gate with pending counter, request termination
// and merge of local and remote responses
//**********************************************************

`timescale 1ns/1ns

module cdc_req_isolate
  import cdc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      req_valid_i,
  input  req_word_t req_i,
  input  logic      isolate_i,
  input  logic      rsp_empty_i,
  input  rsp_word_t rsp_data_i,
  output logic      push_o,
  output req_word_t push_word_o,
  output logic      rsp_pop_o,
  output logic      isolated_o,
  output logic      rsp_valid_o,
  output rsp_word_t rsp_data_o,
  output logic      rsp_err_o
);

  logic [PendWidth-1:0] pending_q;
  logic                 at_limit;
  logic                 terminate;
  logic                 forward;

  assign at_limit  = (pending_q == PendWidth'(MaxPending));
  assign terminate = req_valid_i && (isolate_i || at_limit);
  assign forward   = req_valid_i && !terminate;

  // A termination owns the next output slot, so the pop waits
  assign rsp_pop_o = !rsp_empty_i && !terminate;

  // Accepted requests go to the FIFO one cycle later
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      push_o <= 1'b0;
    end else begin
      push_o <= forward;
    end
  end

  always_ff @(posedge clk_i) begin
    if (forward) begin
      push_word_o <= req_i;
    end
  end

  // Counts from acceptance until the response leaves the FIFO
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else if (forward && !rsp_pop_o) begin
      pending_q <= pending_q + PendWidth'(1);
    end else if (!forward && rsp_pop_o) begin
      pending_q <= pending_q - PendWidth'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      isolated_o <= 1'b0;
    end else begin
      isolated_o <= isolate_i && (pending_q == '0);
    end
  end

  // Response port
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
    end else begin
      rsp_valid_o <= terminate || rsp_pop_o;
      rsp_err_o   <= terminate;
    end
  end

  always_ff @(posedge clk_i) begin
    if (terminate) begin
      rsp_data_o <= '0;
    end else if (rsp_pop_o) begin
      rsp_data_o <= rsp_data_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) pending_q <= PendWidth'(MaxPending))
    else $error("pending count above limit");

endmodule

/* rtl/reg_target.sv */
//**********************************************************
// Destination-domain register file executing requests
//**********************************************************

`timescale 1ns/1ns

module reg_target
  import cdc_pkg::*;
(
  input  logic      dst_clk_i,
  input  logic      rst_i,
  input  logic      req_empty_i,
  input  req_word_t req_word_i,
  output logic      req_pop_o,
  output logic      rsp_push_o,
  output rsp_word_t rsp_data_o
);

  rsp_word_t regs_q [2**RegAddrWidth];
  rsp_word_t rd_word;
  logic      do_write;

  // One request per cycle, answered in the same cycle
  assign req_pop_o  = !req_empty_i;
  assign rsp_push_o = req_pop_o;
  assign do_write   = req_pop_o && req_word_i.op;

  assign rd_word = regs_q[req_word_i.addr];

  // Writes answer with zero, reads apply the mask view
  assign rsp_data_o = req_word_i.op ? '0 : (rd_word & req_word_i.payload.rd.mask);

  always_ff @(posedge dst_clk_i) begin
    if (rst_i) begin
      regs_q <= '{default: '0};
    end else if (do_write) begin
      regs_q[req_word_i.addr] <= req_word_i.payload.wr.data;
    end
  end

endmodule

/* rtl/cdc_wrap.sv */
//**********************************************************
// Top level: isolation gate, request and response FIFOs
// and the destination register target
//**********************************************************

`timescale 1ns/1ns

module cdc_wrap
  import cdc_pkg::*;
(
  input  logic      clk_i,
  input  logic      dst_clk_i,
  input  logic      rst_i,
  input  logic      req_valid_i,
  input  req_word_t req_i,
  input  logic      isolate_i,
  output logic      isolated_o,
  output logic      rsp_valid_o,
  output rsp_word_t rsp_data_o,
  output logic      rsp_err_o
);

  // Source side
  logic      req_push;
  req_word_t req_push_word;
  logic      rsp_pop;
  logic      rsp_empty;
  rsp_word_t rsp_head;

  // Destination side
  logic      req_pop;
  logic      req_empty;
  req_word_t req_head;
  logic      rsp_push;
  rsp_word_t rsp_push_word;

  cdc_req_isolate u_isolate (
    .clk_i       ( clk_i         ),
    .rst_i       ( rst_i         ),
    .req_valid_i ( req_valid_i   ),
    .req_i       ( req_i         ),
    .isolate_i   ( isolate_i     ),
    .rsp_empty_i ( rsp_empty     ),
    .rsp_data_i  ( rsp_head      ),
    .push_o      ( req_push      ),
    .push_word_o ( req_push_word ),
    .rsp_pop_o   ( rsp_pop       ),
    .isolated_o  ( isolated_o    ),
    .rsp_valid_o ( rsp_valid_o   ),
    .rsp_data_o  ( rsp_data_o    ),
    .rsp_err_o   ( rsp_err_o     )
  );

  cdc_async_fifo #(
    .Width ( ReqWidth )
  ) u_req_fifo (
    .wr_clk_i ( clk_i         ),
    .rd_clk_i ( dst_clk_i     ),
    .rst_i    ( rst_i         ),
    .push_i   ( req_push      ),
    .wdata_i  ( req_push_word ),
    .pop_i    ( req_pop       ),
    .rdata_o  ( req_head      ),
    .empty_o  ( req_empty     ),
    .full_o   (               )
  );

  reg_target u_target (
    .dst_clk_i   ( dst_clk_i     ),
    .rst_i       ( rst_i         ),
    .req_empty_i ( req_empty     ),
    .req_word_i  ( req_head      ),
    .req_pop_o   ( req_pop       ),
    .rsp_push_o  ( rsp_push      ),
    .rsp_data_o  ( rsp_push_word )
  );

  cdc_async_fifo #(
    .Width ( RegDataWidth )
  ) u_rsp_fifo (
    .wr_clk_i ( dst_clk_i     ),
    .rd_clk_i ( clk_i         ),
    .rst_i    ( rst_i         ),
    .push_i   ( rsp_push      ),
    .wdata_i  ( rsp_push_word ),
    .pop_i    ( rsp_pop       ),
    .rdata_o  ( rsp_head      ),
    .empty_o  ( rsp_empty     ),
    .full_o   (               )
  );

endmodule

/* sim/cdc_checker.sv */
//**********************************************************
// Response and isolated-flag checker with register model
//**********************************************************

`timescale 1ns/1ns

module cdc_checker
  import cdc_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_valid_i,
  input  req_word_t               req_i,
  input  logic                    isolate_i,
  input  logic                    expect_term_i,
  input  logic [RegDataWidth-1:0] exp_data_i,
  input  logic                    isolated_i,
  input  logic                    rsp_valid_i,
  input  logic [RegDataWidth-1:0] rsp_data_i,
  input  logic                    rsp_err_i,
  output logic                    idle_o,
  output int unsigned             err_cnt_o,
  output int unsigned             check_cnt_o
);

  logic [RegDataWidth-1:0] model [2**RegAddrWidth];
  logic [RegDataWidth-1:0] exp_q [$];
  logic [RegDataWidth-1:0] want;
  int unsigned             fwd_cnt;
  int unsigned             rsp_cnt;
  logic                    term_q;
  logic                    iso_exp_q;
  logic                    remote;

  always @(posedge clk_i) begin
    if (rst_i) begin
      foreach (model[i]) model[i] = '0;
      exp_q.delete();
      fwd_cnt   = 0;
      rsp_cnt   = 0;
      term_q    = 1'b0;
      iso_exp_q = 1'b0;
      idle_o    = 1'b1;
    end else begin
      remote = rsp_valid_i && !rsp_err_i;
      // Terminations answer exactly one cycle after the request
      if ((rsp_valid_i && rsp_err_i) !== term_q) begin
        $display("FAIL rsp_err_o: got %h, expected %h", rsp_valid_i && rsp_err_i, term_q);
        err_cnt_o++;
      end
      if (rsp_valid_i && rsp_err_i) begin
        check_cnt_o++;
        if (rsp_data_i !== '0) begin
          $display("FAIL rsp_data_o: got %h, expected %h", rsp_data_i, 32'h0);
          err_cnt_o++;
        end
      end
      if (remote) begin
        rsp_cnt++;
        check_cnt_o++;
        if (exp_q.size() == 0) begin
          $display("Response arrived with no request outstanding at %0t", $time);
          err_cnt_o++;
        end else begin
          want = exp_q.pop_front();
          if (rsp_data_i !== want) begin
            $display("FAIL rsp_data_o: got %h, expected %h", rsp_data_i, want);
            err_cnt_o++;
          end
        end
      end
      if (isolated_i !== iso_exp_q) begin
        $display("FAIL isolated_o: got %h, expected %h", isolated_i, iso_exp_q);
        err_cnt_o++;
      end
      // Gate pops lead rsp_valid_o by one cycle
      iso_exp_q = isolate_i && (fwd_cnt == rsp_cnt);
      term_q    = req_valid_i && expect_term_i;
      if (req_valid_i && !expect_term_i) begin
        fwd_cnt++;
        if (req_i.op) begin
          model[req_i.addr] = req_i.payload.wr.data;
          exp_q.push_back('0);
        end else begin
          want = model[req_i.addr] & req_i.payload.rd.mask;
          if (want !== exp_data_i) begin
            $display("FAIL exp_data: model %h, stimulus %h", want, exp_data_i);
            err_cnt_o++;
          end
          exp_q.push_back(want);
        end
      end
      idle_o = (exp_q.size() == 0) && !term_q;
    end
  end

  initial begin
    err_cnt_o   = 0;
    check_cnt_o = 0;
  end

endmodule

/* sim/tb_cdc_wrap.sv */
//**********************************************************
// Testbench with clocks, reset and file-driven requests
//**********************************************************

`timescale 1ns/1ns

module tb_cdc_wrap;
  import cdc_pkg::*;

  logic        clk_i;
  logic        dst_clk_i;
  logic        rst_i;
  logic        req_valid_i;
  req_word_t   req_i;
  logic        isolate_i;
  logic        isolated_o;
  logic        rsp_valid_o;
  rsp_word_t   rsp_data_o;
  logic        rsp_err_o;
  logic        expect_term;
  rsp_word_t   exp_data;
  logic        idle;
  int unsigned err_cnt;
  int unsigned check_cnt;

  int          fd;
  int          code;
  int          seed = 63;
  int          test;
  int          op;
  int          iso;
  int          gap;
  int          term;
  int          cur_test;
  int          tests;
  int          test_err_base;
  int          timeouts;
  logic [31:0] addr_h;
  logic [31:0] data_h;
  logic [31:0] exp_h;
  logic [31:0] rnd;
  string       line;

  cdc_wrap u_cdc_wrap (
    .clk_i       ( clk_i       ),
    .dst_clk_i   ( dst_clk_i   ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .isolate_i   ( isolate_i   ),
    .isolated_o  ( isolated_o  ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_data_o  ( rsp_data_o  ),
    .rsp_err_o   ( rsp_err_o   )
  );

  cdc_checker u_checker (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .req_valid_i   ( req_valid_i ),
    .req_i         ( req_i       ),
    .isolate_i     ( isolate_i   ),
    .expect_term_i ( expect_term ),
    .exp_data_i    ( exp_data    ),
    .isolated_i    ( isolated_o  ),
    .rsp_valid_i   ( rsp_valid_o ),
    .rsp_data_i    ( rsp_data_o  ),
    .rsp_err_i     ( rsp_err_o   ),
    .idle_o        ( idle        ),
    .err_cnt_o     ( err_cnt     ),
    .check_cnt_o   ( check_cnt   )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    dst_clk_i = 1'b0;
    forever #15 dst_clk_i = ~dst_clk_i;
  end

  // Waits until every expected response has been seen
  task automatic drain_responses();
    int n;
    n = 0;
    while (!idle && n < 300) begin
      @(negedge clk_i);
      n++;
    end
    if (!idle) begin
      $display("Timed out waiting for responses in test %0d", cur_test);
      timeouts++;
    end
  endtask

  task automatic report_test();
    drain_responses();
    tests++;
    $display("test %0d: %s, %0d errors", cur_test,
             (err_cnt == test_err_base) ? "ok" : "FAIL", err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  initial begin
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    isolate_i   = 1'b0;
    expect_term = 1'b0;
    exp_data    = '0;
    cur_test    = -1;
    tests       = 0;
    timeouts    = 0;
    test_err_base = 0;
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    fd = $fopen("sim/stim_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      timeouts++;
    end
    while (fd != 0 && timeouts == 0 && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%d %d %h %h %d %d %h %d",
                       test, op, addr_h, data_h, iso, gap, exp_h, term);
        if (test != cur_test && cur_test >= 0) report_test();
        cur_test = test;
        // Each line holds its request for one clk_i cycle
        isolate_i   = iso[0];
        req_valid_i = (op < 2);
        req_i.op    = op[0];
        req_i.addr  = addr_h[RegAddrWidth-1:0];
        req_i.payload.wr.data = data_h;
        expect_term = term[0];
        exp_data    = exp_h;
        @(negedge clk_i);
        req_valid_i = 1'b0;
        if (gap == -1) begin
          rnd = $random(seed);
          gap = rnd[1:0];
        end
        if (gap == -2) begin
          drain_responses();
        end else begin
          repeat (gap) @(negedge clk_i);
        end
      end
    end
    if (cur_test >= 0 && timeouts == 0) report_test();
    $display("tests: %0d, checks: %0d, errors: %0d, timeouts: %0d",
             tests, check_cnt, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0 && tests > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim/stim_input.txt */
# test op(0 rd, 1 wr, 2 none) addr(hex) data_or_mask(hex) isolate gap exp_rd(hex) term
# gap: idle cycles, -1 random 0..3, -2 wait for all responses
1 0 0 ffffffff 0 -1 00000000 0
1 0 5 ffffffff 0 -1 00000000 0
1 0 f ffffffff 0 -1 00000000 0
2 1 3 a5a5c3c3 0 2 00000000 0
2 0 3 ffffffff 0 3 a5a5c3c3 0
2 0 3 0000ffff 0 3 0000c3c3 0
2 0 3 f0f0f0f0 0 -1 a0a0c0c0 0
3 1 1 11111111 0 0 00000000 0
3 1 2 22222222 0 0 00000000 0
3 1 4 44444444 0 0 00000000 0
3 0 1 ffffffff 0 0 11111111 0
3 0 2 ff00ff00 0 0 22002200 0
3 0 4 0f0f0f0f 0 0 04040404 0
4 1 6 66666666 0 0 00000000 0
4 1 7 77777777 0 0 00000000 0
4 0 6 ffffffff 0 0 66666666 0
4 0 7 ffffffff 0 0 77777777 0
4 1 8 88888888 0 0 00000000 0
4 0 8 0000ffff 0 0 00008888 0
4 1 9 99999999 0 0 00000000 1
5 1 a 0badf00d 0 0 00000000 0
5 0 a ffffffff 0 0 0badf00d 0
5 2 0 00000000 1 0 00000000 0
5 0 a ffffffff 1 1 00000000 1
5 1 a deadbeef 1 -2 00000000 1
5 2 0 00000000 1 3 00000000 0
6 2 0 00000000 0 2 00000000 0
6 1 b 12345678 0 0 00000000 0
6 0 b ffffffff 0 -1 12345678 0
6 0 a ffffffff 0 -1 0badf00d 0
6 0 9 ffffffff 0 -1 00000000 0

/* files.f */
rtl/cdc_pkg.sv
rtl/cdc_async_fifo.sv
rtl/cdc_req_isolate.sv
rtl/reg_target.sv
rtl/cdc_wrap.sv
sim/cdc_checker.sv
sim/tb_cdc_wrap.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_cdc_wrap
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) sim/stim_input.txt
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
